// ==== design/t04_alu_pkg.sv ====
`default_nettype none

package t04_alu_pkg;

    typedef logic [31:0] word_t;  // operands, result, pc and target

    // one code per alu function, plus a real error code
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_SLL  = 5'd2,
        OP_SLT  = 5'd3,
        OP_SLTU = 5'd4,
        OP_XOR  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_OR   = 5'd8,
        OP_AND  = 5'd9,
        OP_BEQ  = 5'd10,
        OP_BNE  = 5'd11,
        OP_BLT  = 5'd12,
        OP_BGE  = 5'd13,
        OP_BLTU = 5'd14,
        OP_BGEU = 5'd15,
        OP_ERR  = 5'd16
    } operation_t;

    typedef enum logic [6:0] {
        OPC_RTYPE  = 7'b0110011,
        OPC_ITYPE  = 7'b0010011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // sub, sra, srai
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;

    localparam int SHAMT_BITS = 5;

    // instruction field positions
    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_LSB = 0;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT7_MSB = 31;
    localparam int FUNCT7_LSB = 25;

endpackage

`default_nettype wire

// ==== design/t04_alu_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module t04_alu_control_unit
    import t04_alu_pkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] alu_op,             // funct3
    input  logic [6:0] func7,
    output operation_t alu_control_input
);

    // funct3 order shared by r-type and i-type
    function automatic operation_t base_op(input logic [2:0] f3);
        case (f3)
            3'b000:  base_op = OP_ADD;
            3'b001:  base_op = OP_SLL;
            3'b010:  base_op = OP_SLT;
            3'b011:  base_op = OP_SLTU;
            3'b100:  base_op = OP_XOR;
            3'b101:  base_op = OP_SRL;
            3'b110:  base_op = OP_OR;
            default: base_op = OP_AND;
        endcase
    endfunction

    logic is_shift;

    assign is_shift = (alu_op == 3'b001) || (alu_op == 3'b101);

    always_comb
    begin
        alu_control_input = OP_ERR;  // anything not matched below
        case (opcode)
            OPC_RTYPE:
            begin
                if (func7 == FUNCT7_BASE)
                    alu_control_input = base_op(alu_op);
                else if (func7 == FUNCT7_ALT && alu_op == 3'b000)
                    alu_control_input = OP_SUB;
                else if (func7 == FUNCT7_ALT && alu_op == 3'b101)
                    alu_control_input = OP_SRA;
            end
            OPC_ITYPE:
            begin
                if (!is_shift)
                    alu_control_input = base_op(alu_op);  // upper imm bits, not a funct7
                else if (func7 == FUNCT7_BASE)
                    alu_control_input = base_op(alu_op);
                else if (func7 == FUNCT7_ALT && alu_op == 3'b101)
                    alu_control_input = OP_SRA;           // srai
            end
            OPC_BRANCH:
            begin
                case (alu_op)
                    3'b000:  alu_control_input = OP_BEQ;
                    3'b001:  alu_control_input = OP_BNE;
                    3'b100:  alu_control_input = OP_BLT;
                    3'b101:  alu_control_input = OP_BGE;
                    3'b110:  alu_control_input = OP_BLTU;
                    3'b111:  alu_control_input = OP_BGEU;
                    default: alu_control_input = OP_ERR;  // 010 and 011 are reserved
                endcase
            end
            default: alu_control_input = OP_ERR;
        endcase
    end

    // a known opcode must always resolve to a known operation
    always_comb
    begin
        if (!$isunknown(opcode))
            a_op_known: assert final (!$isunknown(alu_control_input));
    end

endmodule

`default_nettype wire

// ==== design/t04_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module t04_imm_gen
    import t04_alu_pkg::*;
(
    input  word_t instr,
    output word_t imm
);

    logic [6:0] opcode;
    word_t      imm_i;
    word_t      imm_b;

    assign opcode = instr[OPCODE_MSB:OPCODE_LSB];

    // i-type: imm[11:0] sits in bits 31..20
    assign imm_i = {{20{instr[31]}}, instr[31:20]};

    // b-type: scattered offset, always even
    assign imm_b = {
        {19{instr[31]}},
        instr[31],          // imm[12]
        instr[7],           // imm[11]
        instr[30:25],       // imm[10:5]
        instr[11:8],        // imm[4:1]
        1'b0
    };

    always_comb
    begin
        case (opcode)
            OPC_ITYPE:  imm = imm_i;
            OPC_BRANCH: imm = imm_b;
            default:    imm = '0;  // r-type and unsupported opcodes
        endcase
    end

endmodule

`default_nettype wire

// ==== design/t04_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module t04_alu
    import t04_alu_pkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] alu_op,
    input  logic [6:0] func7,
    input  word_t      opA,
    input  word_t      opB,
    output word_t      alu_result,
    output logic       zero_flag,
    output logic       err_flag,
    output logic       cond_jump     // branch taken
);

    logic signed [31:0]    opa_signed;
    logic signed [31:0]    opb_signed;
    logic [SHAMT_BITS-1:0] shamt;
    operation_t            alu_control_input;

    assign opa_signed = opA;
    assign opb_signed = opB;
    assign shamt      = opB[SHAMT_BITS-1:0];  // only the low bits count

    t04_alu_control_unit u_ctrl (
        .opcode            (opcode),
        .alu_op            (alu_op),
        .func7             (func7),
        .alu_control_input (alu_control_input)
    );

    always_comb
    begin
        alu_result = '0;
        err_flag   = 1'b0;
        cond_jump  = 1'b0;
        case (alu_control_input)
            OP_ADD:  alu_result = opA + opB;  // carry out dropped
            OP_SUB:  alu_result = opA - opB;
            OP_SLL:  alu_result = opA << shamt;
            OP_SLT:  alu_result = {31'b0, opa_signed < opb_signed};
            OP_SLTU: alu_result = {31'b0, opA < opB};
            OP_XOR:  alu_result = opA ^ opB;
            OP_SRL:  alu_result = opA >> shamt;
            OP_SRA:  alu_result = opa_signed >>> shamt;
            OP_OR:   alu_result = opA | opB;
            OP_AND:  alu_result = opA & opB;
            OP_BEQ:
            begin
                alu_result = {32{opA == opB}};  // all ones when taken
                cond_jump  = (opA == opB);
            end
            OP_BNE:  cond_jump = (opA != opB);
            OP_BLT:  cond_jump = (opa_signed < opb_signed);
            OP_BGE:  cond_jump = (opa_signed >= opb_signed);
            OP_BLTU: cond_jump = (opA < opB);
            OP_BGEU: cond_jump = (opA >= opB);
            default: err_flag = 1'b1;  // OP_ERR leaves result at zero
        endcase
    end

    assign zero_flag = (alu_result == '0);

    // an error must never leak a result or a taken branch
    always_comb
    begin
        a_err_zero: assert final (!err_flag || alu_result == '0);
        a_jump_ok:  assert final (!cond_jump || !err_flag);
    end

endmodule

`default_nettype wire

// ==== design/t04_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module t04_execute
    import t04_alu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  word_t instr,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output logic  out_valid,
    output word_t alu_result,
    output word_t branch_target,
    output logic  zero_flag,
    output logic  err_flag,
    output logic  cond_jump
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;
    word_t      op_b;
    word_t      target;
    word_t      result;
    logic       zero;
    logic       err;
    logic       jump;

    assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
    assign funct3 = instr[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = instr[FUNCT7_MSB:FUNCT7_LSB];

    t04_imm_gen u_imm (
        .instr (instr),
        .imm   (imm)
    );

    // register operand for r-type and branches, immediate otherwise
    assign op_b   = (opcode == OPC_RTYPE || opcode == OPC_BRANCH) ? rs2_data : imm;
    assign target = pc + imm;

    t04_alu u_alu (
        .opcode     (opcode),
        .alu_op     (funct3),
        .func7      (funct7),
        .opA        (rs1_data),
        .opB        (op_b),
        .alu_result (result),
        .zero_flag  (zero),
        .err_flag   (err),
        .cond_jump  (jump)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid     <= 1'b0;
            alu_result    <= '0;
            branch_target <= '0;
            zero_flag     <= 1'b0;
            err_flag      <= 1'b0;
            cond_jump     <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
            begin
                alu_result    <= result;
                branch_target <= target;
                zero_flag     <= zero;
                err_flag      <= err;
                cond_jump     <= jump;
            end  // data holds through idle cycles
        end
    end

    a_reset_invalid: assert property (@(posedge clk) !rst_n |=> !out_valid);

endmodule

`default_nettype wire

// ==== test/t04_execute_vectors.svh ====
`ifndef T04_EXECUTE_VECTORS_SVH
`define T04_EXECUTE_VECTORS_SVH

// one applied instruction and the outputs expected one cycle later
typedef struct packed {
    word_t      instr;
    word_t      pc;
    word_t      rs1;
    word_t      rs2;
    word_t      result;
    logic [2:0] flags;   // {zero_flag, err_flag, cond_jump}
    word_t      target;
} vector_t;

localparam int NUM_VECTORS = 31;

// rs2 = 'hdeadbeef on i-type rows shows that the register operand is ignored
localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{'h002081b3, 'h1000, 'h5, 'h3, 'h8, 3'b000, 'h1000},                       // add
    '{'h402081b3, 'h1000, 'h5, 'h7, 'hfffffffe, 3'b000, 'h1000},                // sub
    '{'h002091b3, 'h1000, 'h1, 'h24, 'h10, 3'b000, 'h1000},                     // sll, shamt 4
    '{'h0020a1b3, 'h1000, 'hffffffff, 'h1, 'h1, 3'b000, 'h1000},                // slt
    '{'h0020b1b3, 'h1000, 'hffffffff, 'h1, 'h0, 3'b100, 'h1000},                // sltu
    '{'h0020c1b3, 'h1000, 'hf0f0f0f0, 'h0ff00ff0, 'hff00ff00, 3'b000, 'h1000},  // xor
    '{'h0020d1b3, 'h1000, 'h80000000, 'h4, 'h08000000, 3'b000, 'h1000},         // srl
    '{'h4020d1b3, 'h1000, 'h80000000, 'h4, 'hf8000000, 3'b000, 'h1000},         // sra
    '{'h0020e1b3, 'h1000, 'hf0f0f0f0, 'h0ff00ff0, 'hfff0fff0, 3'b000, 'h1000},  // or
    '{'h0020f1b3, 'h1000, 'hf0f0f0f0, 'h0ff00ff0, 'h00f000f0, 3'b000, 'h1000},  // and
    '{'hffb08193, 'h1000, 'h5, 'hdeadbeef, 'h0, 3'b100, 'hffb},                 // addi -5
    '{'h7ff08193, 'h2000, 'h1, 'hdeadbeef, 'h800, 3'b000, 'h27ff},              // addi 0x7ff
    '{'hfff0c193, 'h100, 'h12345678, 'hdeadbeef, 'hedcba987, 3'b000, 'hff},     // xori -1
    '{'hfff0a193, 'h100, 'hfffffffe, 'hdeadbeef, 'h1, 3'b000, 'hff},            // slti -1
    '{'h4040d193, 'h100, 'h80000000, 'hdeadbeef, 'hf8000000, 3'b000, 'h504},    // srai, imm 0x404
    '{'h01f0d193, 'h100, 'h80000000, 'hdeadbeef, 'h1, 3'b000, 'h11f},           // srli 31
    '{'h00208863, 'h100, 'h55, 'h55, 'hffffffff, 3'b001, 'h110},                // beq taken
    '{'hfe2088e3, 'h200, 'h55, 'h56, 'h0, 3'b100, 'h1f0},                       // beq not taken
    '{'h00209863, 'h100, 'h1, 'h2, 'h0, 3'b101, 'h110},                         // bne taken
    '{'hfe2098e3, 'h200, 'h7, 'h7, 'h0, 3'b100, 'h1f0},                         // bne not taken
    '{'h0020c863, 'h100, 'hffffffff, 'h1, 'h0, 3'b101, 'h110},                  // blt taken
    '{'hfe20c8e3, 'h200, 'h1, 'hffffffff, 'h0, 3'b100, 'h1f0},                  // blt not taken
    '{'h0020d863, 'h100, 'h1, 'hffffffff, 'h0, 3'b101, 'h110},                  // bge taken
    '{'hfe20d8e3, 'h200, 'hffffffff, 'h1, 'h0, 3'b100, 'h1f0},                  // bge not taken
    '{'h0020e863, 'h100, 'h1, 'hffffffff, 'h0, 3'b101, 'h110},                  // bltu taken
    '{'hfe20e8e3, 'h200, 'hffffffff, 'h1, 'h0, 3'b100, 'h1f0},                  // bltu not taken
    '{'h0020f863, 'h100, 'hffffffff, 'h1, 'h0, 3'b101, 'h110},                  // bgeu taken
    '{'hfe20f8e3, 'h200, 'h1, 'hffffffff, 'h0, 3'b100, 'h1f0},                  // bgeu not taken
    '{'h022081b3, 'h400, 'h5, 'h3, 'h0, 3'b110, 'h400},                         // funct7 0000001
    '{'h0020a863, 'h100, 'h3, 'h3, 'h0, 3'b110, 'h110},                         // branch funct3 010
    '{'h123451b7, 'h300, 'h11, 'h22, 'h0, 3'b110, 'h300}                        // lui, unsupported
};

`endif

// ==== test/t04_execute_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module t04_execute_tb
    import t04_alu_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;

    `include "t04_execute_vectors.svh"

    // worst case is 4 cycles per entry plus reset
    localparam int WATCHDOG_NS = (NUM_VECTORS * 5 + 40) * CLK_PERIOD;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    word_t instr;
    word_t pc;
    word_t rs1_data;
    word_t rs2_data;
    logic  out_valid;
    word_t alu_result;
    word_t branch_target;
    logic  zero_flag;
    logic  err_flag;
    logic  cond_jump;

    t04_execute dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .out_valid     (out_valid),
        .alu_result    (alu_result),
        .branch_target (branch_target),
        .zero_flag     (zero_flag),
        .err_flag      (err_flag),
        .cond_jump     (cond_jump)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic compare_outputs(input vector_t v, input logic valid);
        check_flag("out_valid", valid, out_valid);
        check_word("alu_result", v.result, alu_result);
        check_flag("zero_flag", v.flags[2], zero_flag);
        check_flag("err_flag", v.flags[1], err_flag);
        check_flag("cond_jump", v.flags[0], cond_jump);
        check_word("branch_target", v.target, branch_target);
    endtask

    task automatic apply_vector(input vector_t v);
        in_valid <= 1'b1;
        instr    <= v.instr;
        pc       <= v.pc;
        rs1_data <= v.rs1;
        rs2_data <= v.rs2;
    endtask

    initial
    begin
        vector_t     pending [$];  // applied, result not seen yet
        vector_t     held;         // values the outputs must show
        logic [31:0] rng_state;
        logic        sampled_valid;
        int          next_idx;
        int          gap_left;
        int          checked;

        rst_n     = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        rng_state = 32'hcb7;
        held      = '0;  // reset clears every output
        next_idx  = 0;
        gap_left  = 0;
        checked   = 0;

        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1)
                rst_n <= 1'b1;  // dut still sees reset on this edge
            @(negedge clk);
            compare_outputs(held, 1'b0);
        end

        while (next_idx < NUM_VECTORS || pending.size() != 0)
        begin
            @(posedge clk);
            sampled_valid = in_valid;  // what the dut captures on this edge
            if (next_idx < NUM_VECTORS && gap_left == 0)
            begin
                apply_vector(VECTORS[next_idx]);
                pending.push_back(VECTORS[next_idx]);
                next_idx++;
                rng_state = xorshift32(rng_state);
                gap_left  = int'(rng_state[1:0]);  // 0 to 3 idle cycles
            end
            else
            begin
                in_valid <= 1'b0;
                rng_state = xorshift32(rng_state);
                pc       <= rng_state;   // idle junk that a wrong load would expose
                rs1_data <= ~rng_state;
                if (gap_left > 0)
                    gap_left--;
            end
            @(negedge clk);
            if (sampled_valid)
            begin
                held = pending.pop_front();
                compare_outputs(held, 1'b1);
                checked++;
            end
            else
                compare_outputs(held, 1'b0);  // idle, data must hold
        end

        if (checked == NUM_VECTORS)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d entries were checked", checked, NUM_VECTORS);
            $display("*** TEST FAILED ***");
            $fatal(1, "incomplete run");
        end
    end

endmodule

`default_nettype wire

// ==== t04_execute.f ====
+incdir+test
design/t04_alu_pkg.sv
design/t04_alu_control_unit.sv
design/t04_imm_gen.sv
design/t04_alu.sv
design/t04_execute.sv
test/t04_execute_tb.sv

// ==== Makefile ====
TOP := t04_execute_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f t04_execute.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
